// ==== all.f ====
+incdir+src
src/clk_mon_pkg.sv
src/edge_count_sync.sv
src/rate_meter.sv
src/lock_loss_counter.sv
src/monitor_regs.sv
src/clk_mon.sv
test/clk_mon_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the clock monitor testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module clk_mon_tb -f all.f -o clk_mon_sim \
    && ./obj_dir/clk_mon_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

// ==== test/clk_mon_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clk_mon_defs.svh"

module clk_mon_tb;

    localparam int ref_period   = 4;
    localparam int test0_period = 6;
    localparam int test1_period = 10;
    localparam int ack_limit    = 16;
    localparam int watchdog_ns  = 40 * `CLK_MON_GATE_CYCLES * ref_period;

    logic                     clk_ref;
    logic                     reset;
    logic                     clk_test_0;
    logic                     clk_test_1;
    wire [`CLK_MON_NCLK-1:0]  clk_test;
    logic [`CLK_MON_NCLK-1:0] locked;
    clk_mon_pkg::reg_addr_t   addr;
    clk_mon_pkg::reg_data_t   wr_data;
    logic                     rd;
    logic                     wr;
    clk_mon_pkg::reg_data_t   rd_data;
    logic                     rd_ack;
    logic                     wr_ack;
    logic                     error;

    // Expected response of the access in flight
    clk_mon_pkg::reg_data_t   exp_data;
    logic                     exp_error;
    logic                     tolerant_read;
    int                       unlock_exp [`CLK_MON_NCLK];

    assign clk_test = {clk_test_1, clk_test_0};

    clk_mon clk_mon_i (
        .clk_ref  (clk_ref),
        .reset    (reset),
        .clk_test (clk_test),
        .locked   (locked),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd       (rd),
        .wr       (wr),
        .rd_data  (rd_data),
        .rd_ack   (rd_ack),
        .wr_ack   (wr_ack),
        .error    (error)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clocks

    initial
    begin
        clk_ref = 1'b0;
        forever #(ref_period / 2) clk_ref = ~clk_ref;
    end

    initial
    begin
        clk_test_0 = 1'b0;
        forever #(test0_period / 2) clk_test_0 = ~clk_test_0;
    end

    initial
    begin
        clk_test_1 = 1'b0;
        forever #(test1_period / 2) clk_test_1 = ~clk_test_1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and reference model

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[FAIL] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        stop_on_failure();
    endtask

    // Edges of the test clock in one window, rounded
    function automatic int expected_rate(input int period);
        return (2 * `CLK_MON_GATE_CYCLES * ref_period + period) / (2 * period);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    assert property (@(posedge clk_ref) $fell(reset) |-> (rd_data == '0))
        else report_value("rd_data", 0, $sampled(rd_data));

    // Ack exactly one cycle after a one-cycle strobe
    assert property (@(posedge clk_ref) disable iff (reset) rd_ack == $past(rd))
        else report_value("rd_ack", !$sampled(rd_ack), $sampled(rd_ack));

    assert property (@(posedge clk_ref) disable iff (reset) wr_ack == $past(wr))
        else report_value("wr_ack", !$sampled(wr_ack), $sampled(wr_ack));

    assert property (@(posedge clk_ref) disable iff (reset) !(rd_ack && wr_ack))
        else
        begin
            $display("[FAIL] %0t: read and write acknowledge were high together", $time);
            stop_on_failure();
        end

    assert property (@(posedge clk_ref) disable iff (reset)
        error == ((rd_ack || wr_ack) && exp_error))
        else report_value("error", !$sampled(error), $sampled(error));

    assert property (@(posedge clk_ref) disable iff (reset)
        (rd_ack && !tolerant_read) |-> (rd_data == exp_data))
        else report_value("rd_data", exp_data, $sampled(rd_data));

    // Rate reads allow two edges of synchronizer slack
    assert property (@(posedge clk_ref) disable iff (reset)
        (rd_ack && tolerant_read) |-> ((rd_data + 32'd2 >= exp_data) &&
                                       (rd_data <= exp_data + 32'd2)))
        else report_value("rd_data", exp_data, $sampled(rd_data));

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks

    task automatic wait_for_ack(input logic is_read);
        int waited;
        waited = 0;
        while (!(is_read ? rd_ack : wr_ack) && waited < ack_limit)
        begin
            @(negedge clk_ref);
            waited++;
        end
        if (!(is_read ? rd_ack : wr_ack))
        begin
            $display("[FAIL] %0t: no acknowledge for the bus access", $time);
            stop_on_failure();
        end
        else
        begin
            // Keep expectations steady through the checking edge
            @(negedge clk_ref);
        end
    endtask

    task automatic bus_read(input clk_mon_pkg::reg_addr_t a,
                            input clk_mon_pkg::reg_data_t expected, input logic tolerant);
        exp_data      = expected;
        tolerant_read = tolerant;
        exp_error     = (a >= clk_mon_pkg::reg_addr_t'(2 * `CLK_MON_NCLK));
        addr          = a;
        rd            = 1'b1;
        @(negedge clk_ref);
        rd = 1'b0;
        wait_for_ack(1'b1);
    endtask

    task automatic bus_write(input clk_mon_pkg::reg_addr_t a, input clk_mon_pkg::reg_data_t d);
        exp_error = (a >= clk_mon_pkg::reg_addr_t'(2 * `CLK_MON_NCLK));
        addr      = a;
        wr_data   = d;
        wr        = 1'b1;
        @(negedge clk_ref);
        wr = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic drop_lock(input int ch, input int low_cycles, input int high_cycles);
        locked[ch] = 1'b0;
        repeat (low_cycles) @(negedge clk_ref);
        locked[ch] = 1'b1;
        repeat (high_cycles) @(negedge clk_ref);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial
    begin
        int pulses;
        void'($urandom(32'h8079_c994));
        reset         = 1'b1;
        locked        = '1;
        addr          = '0;
        wr_data       = '0;
        rd            = 1'b0;
        wr            = 1'b0;
        exp_data      = '0;
        exp_error     = 1'b0;
        tolerant_read = 1'b0;
        repeat (16) @(negedge clk_ref);
        reset = 1'b0;
        @(negedge clk_ref);

        // Nothing measured yet
        for (int a = 0; a < 2 * `CLK_MON_NCLK; a++)
        begin
            bus_read(clk_mon_pkg::reg_addr_t'(a), '0, 1'b0);
        end

        // Baseline window plus one measured window
        repeat (2 * `CLK_MON_GATE_CYCLES + 64) @(negedge clk_ref);
        bus_read(0, expected_rate(test0_period), 1'b1);
        bus_read(2, expected_rate(test1_period), 1'b1);

        for (int ch = 0; ch < `CLK_MON_NCLK; ch++)
        begin
            pulses         = 1 + int'($urandom % 8);
            unlock_exp[ch] = pulses;
            for (int p = 0; p < pulses; p++)
            begin
                drop_lock(ch, 4 + int'($urandom % 4), 4 + int'($urandom % 4));
            end
        end
        repeat (8) @(negedge clk_ref);
        for (int ch = 0; ch < `CLK_MON_NCLK; ch++)
        begin
            bus_read(clk_mon_pkg::reg_addr_t'(2 * ch + 1), unlock_exp[ch], 1'b0);
        end

        // Clear channel 0 only, then poke a read-only rate register
        bus_write(1, $urandom);
        unlock_exp[0] = 0;
        bus_read(1, unlock_exp[0], 1'b0);
        bus_read(3, unlock_exp[1], 1'b0);
        bus_write(0, $urandom);
        bus_read(0, expected_rate(test0_period), 1'b1);

        for (int a = 2 * `CLK_MON_NCLK; a < (1 << `CLK_MON_ADDR_W); a++)
        begin
            bus_read(clk_mon_pkg::reg_addr_t'(a), '0, 1'b0);
            bus_write(clk_mon_pkg::reg_addr_t'(a), $urandom);
        end

        $display("All tests passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// ==== src/clk_mon.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clk_mon_defs.svh"

module clk_mon
(
    input  wire                           clk_ref,
    input  wire                           reset,
    input  wire [`CLK_MON_NCLK-1:0]       clk_test,
    input  wire [`CLK_MON_NCLK-1:0]       locked,
    input  wire clk_mon_pkg::reg_addr_t   addr,
    input  wire clk_mon_pkg::reg_data_t   wr_data,
    input  wire                           rd,
    input  wire                           wr,
    output wire clk_mon_pkg::reg_data_t   rd_data,
    output wire                           rd_ack,
    output wire                           wr_ack,
    output wire                           error
);

    clk_mon_pkg::edge_count_t    edge_count [`CLK_MON_NCLK];
    clk_mon_pkg::rate_t          rate [`CLK_MON_NCLK];
    clk_mon_pkg::unlock_count_t  unlocks [`CLK_MON_NCLK];
    logic [`CLK_MON_NCLK-1:0]    unlock_clear;

    ////////////////////////////////////////////////////////////////////////////
    // One measurement channel per monitored clock

    for (genvar i = 0; i < `CLK_MON_NCLK; i++)
    begin : chan

        edge_count_sync edge_count_sync_i (
            .clk_test   (clk_test[i]),
            .clk_ref    (clk_ref),
            .reset      (reset),
            .edge_count (edge_count[i])
        );

        rate_meter rate_meter_i (
            .clk_ref    (clk_ref),
            .reset      (reset),
            .edge_count (edge_count[i]),
            .rate       (rate[i])
        );

        lock_loss_counter lock_loss_counter_i (
            .clk_ref      (clk_ref),
            .reset        (reset),
            .locked       (locked[i]),
            .unlock_clear (unlock_clear[i]),
            .unlocks      (unlocks[i])
        );

    end

    // Register bank shared by all channels
    monitor_regs monitor_regs_i (
        .clk_ref      (clk_ref),
        .reset        (reset),
        .addr         (addr),
        .wr_data      (wr_data),
        .rd           (rd),
        .wr           (wr),
        .rate         (rate),
        .unlocks      (unlocks),
        .rd_data      (rd_data),
        .rd_ack       (rd_ack),
        .wr_ack       (wr_ack),
        .error        (error),
        .unlock_clear (unlock_clear)
    );

endmodule

`default_nettype wire

// ==== src/monitor_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clk_mon_defs.svh"

module monitor_regs
(
    input  wire                              clk_ref,
    input  wire                              reset,
    input  wire clk_mon_pkg::reg_addr_t      addr,
    input  wire clk_mon_pkg::reg_data_t      wr_data,
    input  wire                              rd,
    input  wire                              wr,
    input  wire clk_mon_pkg::rate_t          rate [`CLK_MON_NCLK],
    input  wire clk_mon_pkg::unlock_count_t  unlocks [`CLK_MON_NCLK],
    output clk_mon_pkg::reg_data_t           rd_data,
    output logic                             rd_ack,
    output logic                             wr_ack,
    output logic                             error,
    output logic [`CLK_MON_NCLK-1:0]         unlock_clear
);

    // wr_data has no storage in this map, any write to an unlock
    // register clears it whatever the value

    clk_mon_pkg::reg_data_t read_value;
    logic                   mapped;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode

    // Two registers per channel, rate at even and unlocks at odd addresses
    assign mapped = (addr < clk_mon_pkg::reg_addr_t'(2 * `CLK_MON_NCLK));

    always_comb
    begin
        read_value = '0;
        for (int i = 0; i < `CLK_MON_NCLK; i++)
        begin
            if (addr == clk_mon_pkg::reg_addr_t'(2 * i))
            begin
                read_value = rate[i];
            end
            else if (addr == clk_mon_pkg::reg_addr_t'(2 * i + 1))
            begin
                read_value = unlocks[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response and clear pulses

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            rd_data      <= '0;
            rd_ack       <= 1'b0;
            wr_ack       <= 1'b0;
            error        <= 1'b0;
            unlock_clear <= '0;
        end
        else
        begin
            rd_ack <= rd;
            wr_ack <= wr;
            error  <= (rd || wr) && !mapped;
            // Held until the next read
            if (rd)
            begin
                rd_data <= read_value;
            end
            for (int i = 0; i < `CLK_MON_NCLK; i++)
            begin
                unlock_clear[i] <= wr && (addr == clk_mon_pkg::reg_addr_t'(2 * i + 1));
            end
        end
    end

    // Master never strobes both ways at once
    assert property (@(posedge clk_ref) disable iff (reset) !(rd && wr));

    // So the acks never overlap either
    assert property (@(posedge clk_ref) disable iff (reset) !(rd_ack && wr_ack));

endmodule

`default_nettype wire

// ==== src/lock_loss_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module lock_loss_counter
(
    input  wire                         clk_ref,
    input  wire                         reset,
    input  wire                         locked,
    input  wire                         unlock_clear,
    output clk_mon_pkg::unlock_count_t  unlocks
);

    logic locked_meta;
    logic locked_sync;
    logic locked_prev;
    logic lock_lost;

    // Two-flop synchronizer plus one flop for edge detect
    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            locked_meta <= 1'b0;
            locked_sync <= 1'b0;
            locked_prev <= 1'b0;
        end
        else
        begin
            locked_meta <= locked;
            locked_sync <= locked_meta;
            locked_prev <= locked_sync;
        end
    end

    assign lock_lost = locked_prev && !locked_sync;

    // Clear wins over a count in the same cycle
    always_ff @(posedge clk_ref)
    begin
        if (reset || unlock_clear)
        begin
            unlocks <= '0;
        end
        else if (lock_lost && (unlocks != '1))
        begin
            unlocks <= unlocks + 1'b1;
        end
    end

    // Only a software clear may pull the count down
    assert property (@(posedge clk_ref) disable iff (reset)
        (unlocks < $past(unlocks)) |-> $past(unlock_clear));

endmodule

`default_nettype wire

// ==== src/rate_meter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "clk_mon_defs.svh"

module rate_meter
(
    input  wire                            clk_ref,
    input  wire                            reset,
    input  wire clk_mon_pkg::edge_count_t  edge_count,
    output clk_mon_pkg::rate_t             rate
);

    localparam int win_w = $clog2(`CLK_MON_GATE_CYCLES);

    clk_mon_pkg::meter_state_t state;
    logic [win_w-1:0]          win_cnt;
    logic                      window_end;
    clk_mon_pkg::edge_count_t  baseline;
    clk_mon_pkg::edge_count_t  diff;

    ////////////////////////////////////////////////////////////////////////////
    // Window timing

    assign window_end = (win_cnt == win_w'(`CLK_MON_GATE_CYCLES - 1));

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            win_cnt <= '0;
        end
        else if (window_end)
        begin
            win_cnt <= '0;
        end
        else
        begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Measurement FSM

    // Wraps naturally at 2^16
    assign diff = edge_count - baseline;

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            state    <= clk_mon_pkg::meter_start;
            baseline <= '0;
            rate     <= '0;
        end
        else if (window_end)
        begin
            // Current count is always the next baseline
            baseline <= edge_count;
            case (state)
                clk_mon_pkg::meter_start:
                begin
                    state <= clk_mon_pkg::meter_run;
                end
                clk_mon_pkg::meter_run:
                begin
                    rate <= clk_mon_pkg::rate_t'(diff);
                end
                default:
                begin
                    state <= clk_mon_pkg::meter_start;
                end
            endcase
        end
    end

    // Result only moves right after a window boundary
    assert property (@(posedge clk_ref) disable iff (reset)
        $changed(rate) |-> $past(window_end));

endmodule

`default_nettype wire

// ==== src/edge_count_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module edge_count_sync
(
    input  wire                       clk_test,
    input  wire                       clk_ref,
    input  wire                       reset,
    output clk_mon_pkg::edge_count_t  edge_count
);

    localparam int cnt_w = $bits(clk_mon_pkg::edge_count_t);

    logic [1:0]               test_reset_sync;
    logic                     test_reset;
    clk_mon_pkg::edge_count_t bin_cnt;
    clk_mon_pkg::edge_count_t bin_next;
    clk_mon_pkg::edge_count_t gray_test;
    clk_mon_pkg::edge_count_t gray_meta;
    clk_mon_pkg::edge_count_t gray_sync;

    ////////////////////////////////////////////////////////////////////////////
    // Test clock domain

    // Bring reset over to clk_test
    always_ff @(posedge clk_test)
    begin
        test_reset_sync <= {test_reset_sync[0], reset};
    end

    assign test_reset = test_reset_sync[1];

    assign bin_next = bin_cnt + 1'b1;

    // Gray is taken from the next count so both registers move together
    always_ff @(posedge clk_test)
    begin
        if (test_reset)
        begin
            bin_cnt   <= '0;
            gray_test <= '0;
        end
        else
        begin
            bin_cnt   <= bin_next;
            gray_test <= bin_next ^ (bin_next >> 1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference clock domain

    always_ff @(posedge clk_ref)
    begin
        if (reset)
        begin
            gray_meta <= '0;
            gray_sync <= '0;
        end
        else
        begin
            gray_meta <= gray_test;
            gray_sync <= gray_meta;
        end
    end

    // Gray to binary, MSB first
    always_comb
    begin
        edge_count[cnt_w-1] = gray_sync[cnt_w-1];
        for (int i = cnt_w - 2; i >= 0; i--)
        begin
            edge_count[i] = edge_count[i+1] ^ gray_sync[i];
        end
    end

    // At most one bit may move per reference cycle across the crossing
    assert property (@(posedge clk_ref) disable iff (reset)
        $onehot0(gray_sync ^ $past(gray_sync)));

endmodule

`default_nettype wire

// ==== src/clk_mon_pkg.sv ====
`default_nettype none

`include "clk_mon_defs.svh"

package clk_mon_pkg;

    // Edge counter, binary or Gray coded
    typedef logic [`CLK_MON_EDGE_W-1:0] edge_count_t;

    // Measurement results as seen by software
    typedef logic [`CLK_MON_DATA_W-1:0] rate_t;
    typedef logic [`CLK_MON_DATA_W-1:0] unlock_count_t;

    // Register bus
    typedef logic [`CLK_MON_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CLK_MON_DATA_W-1:0] reg_data_t;

    // Rate meter FSM
    typedef enum logic {meter_start, meter_run} meter_state_t;

endpackage

`default_nettype wire

// ==== src/clk_mon_defs.svh ====
`ifndef CLK_MON_DEFS_SVH
`define CLK_MON_DEFS_SVH

// Number of monitored clocks
`define CLK_MON_NCLK          2

// Measurement window in clk_ref cycles
`define CLK_MON_GATE_CYCLES   1024

// Datapath and register bus widths
`define CLK_MON_EDGE_W        16
`define CLK_MON_ADDR_W        4
`define CLK_MON_DATA_W        32

`endif
